// File: design/soc_pkg.sv
// soc bus subsystem shared definitions
// bus widths, device address map and register offsets
`default_nettype none

package soc_pkg;

  localparam int BUS_AW = 16;
  localparam int BUS_DW = 32;

  // upper address bits select the device
  localparam int DEV_SEL_LSB = 12;

  // device windows, ram covers the low 1 KiB only
  localparam logic [BUS_AW-1:0] RAM_BASE   = 16'h0000;
  localparam int                RAM_AW     = 10;
  localparam logic [BUS_AW-1:0] GPIO_BASE  = 16'h1000;
  localparam logic [BUS_AW-1:0] TIMER_BASE = 16'h2000;
  localparam logic [BUS_AW-1:0] INTC_BASE  = 16'h3000;

  // gpio registers
  localparam logic [DEV_SEL_LSB-1:0] GPIO_DATA_IN    = 12'h000;
  localparam logic [DEV_SEL_LSB-1:0] GPIO_DATA_OUT   = 12'h004;
  localparam logic [DEV_SEL_LSB-1:0] GPIO_OE         = 12'h008;
  localparam logic [DEV_SEL_LSB-1:0] GPIO_INTR_STATE = 12'h00C;
  localparam logic [DEV_SEL_LSB-1:0] GPIO_INTR_EN    = 12'h010;

  // timer registers
  localparam logic [DEV_SEL_LSB-1:0] TMR_COUNT      = 12'h000;
  localparam logic [DEV_SEL_LSB-1:0] TMR_COMPARE    = 12'h004;
  localparam logic [DEV_SEL_LSB-1:0] TMR_CTRL       = 12'h008;
  localparam logic [DEV_SEL_LSB-1:0] TMR_INTR_STATE = 12'h00C;

  // interrupt controller registers
  localparam logic [DEV_SEL_LSB-1:0] INTC_PENDING = 12'h000;
  localparam logic [DEV_SEL_LSB-1:0] INTC_ENABLE  = 12'h004;
  localparam logic [DEV_SEL_LSB-1:0] INTC_CLAIM   = 12'h008;

  // interrupt source indices
  localparam int IRQ_GPIO  = 0;
  localparam int IRQ_TIMER = 1;

endpackage

`default_nettype wire

// File: design/soc_bus_if.sv
// single-word bus port between the crossbar and one device
// a request is a one-cycle strobe, answered on the next edge
`timescale 1ns/100ps
`default_nettype none

interface soc_bus_if import soc_pkg::*; ();

  logic              req;
  logic              we;
  logic [BUS_AW-1:0] addr;
  logic [BUS_DW-1:0] wdata;

  // response, valid for exactly one cycle
  logic              rvalid;
  logic [BUS_DW-1:0] rdata;
  logic              err;

  modport host (
    output req, we, addr, wdata,
    input  rvalid, rdata, err
  );

  modport dev (
    input  req, we, addr, wdata,
    output rvalid, rdata, err
  );

endinterface

`default_nettype wire

// File: design/bus_xbar.sv
// bus crossbar, one host to four devices
// decodes the address, answers unmapped accesses with an error
`timescale 1ns/100ps
`default_nettype none

module bus_xbar import soc_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  soc_bus_if.dev  host,
  soc_bus_if.host ram,
  soc_bus_if.host gpio,
  soc_bus_if.host timer,
  soc_bus_if.host intc
);

  logic ram_hit;
  logic gpio_hit;
  logic timer_hit;
  logic intc_hit;
  logic unm_valid_q;

  // ram window is smaller than a device slot, the rest is a hole
  assign ram_hit   = host.addr[BUS_AW-1:RAM_AW] == RAM_BASE[BUS_AW-1:RAM_AW];
  assign gpio_hit  = host.addr[BUS_AW-1:DEV_SEL_LSB] == GPIO_BASE[BUS_AW-1:DEV_SEL_LSB];
  assign timer_hit = host.addr[BUS_AW-1:DEV_SEL_LSB] == TIMER_BASE[BUS_AW-1:DEV_SEL_LSB];
  assign intc_hit  = host.addr[BUS_AW-1:DEV_SEL_LSB] == INTC_BASE[BUS_AW-1:DEV_SEL_LSB];

  // strobe only to the selected device
  assign ram.req   = host.req & ram_hit;
  assign gpio.req  = host.req & gpio_hit;
  assign timer.req = host.req & timer_hit;
  assign intc.req  = host.req & intc_hit;

  assign ram.we    = host.we;
  assign ram.addr  = host.addr;
  assign ram.wdata = host.wdata;

  assign gpio.we    = host.we;
  assign gpio.addr  = host.addr;
  assign gpio.wdata = host.wdata;

  assign timer.we    = host.we;
  assign timer.addr  = host.addr;
  assign timer.wdata = host.wdata;

  assign intc.we    = host.we;
  assign intc.addr  = host.addr;
  assign intc.wdata = host.wdata;

  // own error response for unmapped addresses
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      unm_valid_q <= 1'b0;
    end else begin
      unm_valid_q <= host.req & ~(ram_hit | gpio_hit | timer_hit | intc_hit);
    end
  end

  // devices hold rdata at zero when idle, so an OR is enough
  assign host.rvalid = ram.rvalid | gpio.rvalid | timer.rvalid | intc.rvalid | unm_valid_q;
  assign host.rdata  = ram.rdata | gpio.rdata | timer.rdata | intc.rdata;
  assign host.err    = ram.err | gpio.err | timer.err | intc.err | unm_valid_q;

  a_single_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({ram.rvalid, gpio.rvalid, timer.rvalid, intc.rvalid, unm_valid_q}));

endmodule

`default_nettype wire

// File: design/sram_dev.sv
// single-port word ram behind a bus port
// read data is registered and returned on the next cycle
`timescale 1ns/100ps
`default_nettype none

module sram_dev import soc_pkg::*; #(
  parameter int RamDepth = 256
) (
  input  logic    clk_i,
  soc_bus_if.dev  bus
);

  localparam int IdxW    = $clog2(RamDepth);
  localparam int ByteOfs = $clog2(BUS_DW / 8);

  logic [BUS_DW-1:0] mem [RamDepth];
  logic [IdxW-1:0]   idx;
  logic              rvalid_q;
  logic [BUS_DW-1:0] rdata_q;

  // word index, byte offset bits dropped
  assign idx = bus.addr[ByteOfs +: IdxW];

  always_ff @(posedge clk_i) begin
    if (bus.req && bus.we) begin
      mem[idx] <= bus.wdata;
    end
  end

  // writes answer with zero data
  always_ff @(posedge clk_i) begin
    rvalid_q <= bus.req;
    rdata_q  <= (bus.req && !bus.we) ? mem[idx] : '0;
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  // every word in the window exists
  assign bus.err    = 1'b0;

endmodule

`default_nettype wire

// File: design/gpio_dev.sv
// gpio block with direction control and rising-edge interrupts
`timescale 1ns/100ps
`default_nettype none

module gpio_dev import soc_pkg::*; #(
  parameter int GpioWidth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  soc_bus_if.dev               bus,
  input  logic [GpioWidth-1:0] gpio_i,
  output logic [GpioWidth-1:0] gpio_o,
  output logic [GpioWidth-1:0] gpio_en_o,
  output logic                 irq_o
);

  logic [DEV_SEL_LSB-1:0] off;
  logic                   wr;
  logic                   known;
  logic                   ro;
  logic                   bad;
  logic [BUS_DW-1:0]      rd_val;
  logic [GpioWidth-1:0]   sync1_q, sync2_q, prev_q;
  logic [GpioWidth-1:0]   data_out_q, oe_q, intr_state_q, intr_en_q;
  logic [GpioWidth-1:0]   rise;
  logic [GpioWidth-1:0]   clr;
  logic                   rvalid_q, err_q;
  logic [BUS_DW-1:0]      rdata_q;

  assign off = bus.addr[DEV_SEL_LSB-1:0];
  assign wr  = bus.req & bus.we;

  always_comb begin
    rd_val = '0;
    known  = 1'b1;
    ro     = 1'b0;
    case (off)
      GPIO_DATA_IN: begin
        rd_val = BUS_DW'(sync2_q);
        ro     = 1'b1;
      end
      GPIO_DATA_OUT:   rd_val = BUS_DW'(data_out_q);
      GPIO_OE:         rd_val = BUS_DW'(oe_q);
      GPIO_INTR_STATE: rd_val = BUS_DW'(intr_state_q);
      GPIO_INTR_EN:    rd_val = BUS_DW'(intr_en_q);
      default:         known  = 1'b0;
    endcase
  end

  assign bad = ~known | (bus.we & ro);

  // edge seen on the synchronized input, set wins over clear
  assign rise = sync2_q & ~prev_q;
  assign clr  = (wr && off == GPIO_INTR_STATE) ? bus.wdata[GpioWidth-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q      <= '0;
      sync2_q      <= '0;
      prev_q       <= '0;
      data_out_q   <= '0;
      oe_q         <= '0;
      intr_state_q <= '0;
      intr_en_q    <= '0;
    end else begin
      sync1_q      <= gpio_i;
      sync2_q      <= sync1_q;
      prev_q       <= sync2_q;
      intr_state_q <= (intr_state_q & ~clr) | rise;
      if (wr && off == GPIO_DATA_OUT) data_out_q <= bus.wdata[GpioWidth-1:0];
      if (wr && off == GPIO_OE) oe_q <= bus.wdata[GpioWidth-1:0];
      if (wr && off == GPIO_INTR_EN) intr_en_q <= bus.wdata[GpioWidth-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      err_q    <= bus.req & bad;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= (bus.req && !bus.we && !bad) ? rd_val : '0;
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = err_q;
  assign gpio_o     = data_out_q;
  assign gpio_en_o  = oe_q;
  assign irq_o      = |(intr_state_q & intr_en_q);

endmodule

`default_nettype wire

// File: design/timer_dev.sv
// compare timer, free-running counter with an expiry interrupt
`timescale 1ns/100ps
`default_nettype none

module timer_dev import soc_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  soc_bus_if.dev bus,
  output logic   irq_o
);

  logic [DEV_SEL_LSB-1:0] off;
  logic                   wr;
  logic                   known;
  logic [BUS_DW-1:0]      rd_val;
  logic [BUS_DW-1:0]      count_q, compare_q;
  logic                   enable_q;
  logic                   intr_q;
  logic                   expired;
  logic                   rvalid_q, err_q;
  logic [BUS_DW-1:0]      rdata_q;

  assign off = bus.addr[DEV_SEL_LSB-1:0];
  assign wr  = bus.req & bus.we;

  always_comb begin
    rd_val = '0;
    known  = 1'b1;
    case (off)
      TMR_COUNT:      rd_val = count_q;
      TMR_COMPARE:    rd_val = compare_q;
      TMR_CTRL:       rd_val = BUS_DW'(enable_q);
      TMR_INTR_STATE: rd_val = BUS_DW'(intr_q);
      default:        known  = 1'b0;
    endcase
  end

  assign expired = enable_q & (count_q >= compare_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q   <= '0;
      compare_q <= '0;
      enable_q  <= 1'b0;
      intr_q    <= 1'b0;
    end else begin
      // software load beats the increment
      if (wr && off == TMR_COUNT) begin
        count_q <= bus.wdata;
      end else if (enable_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr && off == TMR_COMPARE) compare_q <= bus.wdata;
      if (wr && off == TMR_CTRL) enable_q <= bus.wdata[0];
      // write 1 to clear, re-set while still expired
      intr_q <= expired | (intr_q & ~(wr && off == TMR_INTR_STATE && bus.wdata[0]));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      err_q    <= bus.req & ~known;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= (bus.req && !bus.we && known) ? rd_val : '0;
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = err_q;
  assign irq_o      = intr_q;

endmodule

`default_nettype wire

// File: design/intr_ctrl.sv
// interrupt controller, level sources combined into one request
// claim id is one plus the lowest pending and enabled source
`timescale 1ns/100ps
`default_nettype none

module intr_ctrl import soc_pkg::*; #(
  parameter  int NumIrq = 2,
  localparam int IdW    = $clog2(NumIrq + 1)
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  soc_bus_if.dev            bus,
  input  logic [NumIrq-1:0] intr_src_i,
  output logic              irq_o,
  output logic [IdW-1:0]    irq_id_o
);

  logic [DEV_SEL_LSB-1:0] off;
  logic                   known;
  logic                   ro;
  logic                   bad;
  logic [BUS_DW-1:0]      rd_val;
  logic [NumIrq-1:0]      pending_q, enable_q;
  logic [IdW-1:0]         claim;
  logic                   rvalid_q, err_q;
  logic [BUS_DW-1:0]      rdata_q;

  assign off = bus.addr[DEV_SEL_LSB-1:0];

  // scan downwards so the lowest index is left in claim
  always_comb begin
    claim = '0;
    for (int i = NumIrq - 1; i >= 0; i--) begin
      if (pending_q[i] && enable_q[i]) begin
        claim = IdW'(i + 1);
      end
    end
  end

  always_comb begin
    rd_val = '0;
    known  = 1'b1;
    ro     = 1'b1;
    case (off)
      INTC_PENDING: rd_val = BUS_DW'(pending_q);
      INTC_ENABLE: begin
        rd_val = BUS_DW'(enable_q);
        ro     = 1'b0;
      end
      INTC_CLAIM:   rd_val = BUS_DW'(claim);
      default:      known  = 1'b0;
    endcase
  end

  assign bad = ~known | (bus.we & ro);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      rvalid_q  <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      pending_q <= intr_src_i;
      if (bus.req && bus.we && off == INTC_ENABLE) enable_q <= bus.wdata[NumIrq-1:0];
      rvalid_q  <= bus.req;
      err_q     <= bus.req & bad;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= (bus.req && !bus.we && !bad) ? rd_val : '0;
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = err_q;
  assign irq_o      = |(pending_q & enable_q);
  assign irq_id_o   = claim;

  a_irq_matches_id: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_o == (irq_id_o != '0));

endmodule

`default_nettype wire

// File: design/soc_top.sv
// soc bus subsystem top level
// host bus port, crossbar, ram, gpio, timer and interrupt controller
`timescale 1ns/100ps
`default_nettype none

module soc_top import soc_pkg::*; #(
  parameter  int RamDepth  = 256,
  parameter  int GpioWidth = 8,
  localparam int NumIrq    = 2,
  localparam int IrqIdW    = $clog2(NumIrq + 1)
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // external bus host
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [BUS_AW-1:0]    addr_i,
  input  logic [BUS_DW-1:0]    wdata_i,
  output logic                 rvalid_o,
  output logic [BUS_DW-1:0]    rdata_o,
  output logic                 err_o,

  // gpio pads
  input  logic [GpioWidth-1:0] gpio_i,
  output logic [GpioWidth-1:0] gpio_o,
  output logic [GpioWidth-1:0] gpio_en_o,

  // interrupt request to the host
  output logic                 irq_o,
  output logic [IrqIdW-1:0]    irq_id_o
);

  soc_bus_if host_bus ();
  soc_bus_if ram_bus ();
  soc_bus_if gpio_bus ();
  soc_bus_if timer_bus ();
  soc_bus_if intc_bus ();

  logic              gpio_irq;
  logic              timer_irq;
  logic [NumIrq-1:0] intr_src;

  assign host_bus.req   = req_i;
  assign host_bus.we    = we_i;
  assign host_bus.addr  = addr_i;
  assign host_bus.wdata = wdata_i;
  assign rvalid_o       = host_bus.rvalid;
  assign rdata_o        = host_bus.rdata;
  assign err_o          = host_bus.err;

  assign intr_src[IRQ_GPIO]  = gpio_irq;
  assign intr_src[IRQ_TIMER] = timer_irq;

  bus_xbar u_xbar (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .host    (host_bus),
    .ram     (ram_bus),
    .gpio    (gpio_bus),
    .timer   (timer_bus),
    .intc    (intc_bus)
  );

  sram_dev #(.RamDepth(RamDepth)) u_sram (
    .clk_i (clk_i),
    .bus   (ram_bus)
  );

  gpio_dev #(.GpioWidth(GpioWidth)) u_gpio (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .bus       (gpio_bus),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o),
    .irq_o     (gpio_irq)
  );

  timer_dev u_timer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (timer_bus),
    .irq_o   (timer_irq)
  );

  intr_ctrl #(.NumIrq(NumIrq)) u_intc (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .bus        (intc_bus),
    .intr_src_i (intr_src),
    .irq_o      (irq_o),
    .irq_id_o   (irq_id_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_top.sv
// testbench for the soc bus subsystem
// drives the host bus, keeps a shadow of ram and registers, checks every response
`timescale 1ns/100ps
`default_nettype none

module tb_top import soc_pkg::*; ();

  localparam int MAX_CYCLES = 20000;
  localparam int RAM_WORDS  = 256;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic        we;
  logic [15:0] addr;
  logic [31:0] wdata;
  logic        rvalid;
  logic [31:0] rdata;
  logic        err;
  logic [7:0]  gpio_in;
  logic [7:0]  gpio_out;
  logic [7:0]  gpio_en;
  logic        irq;
  logic [1:0]  irq_id;

  integer      seed = 32'h174a_fdec;
  int          cyc = 0;
  logic [31:0] last_rdata;
  logic [15:0] err_addrs [9];

  // expected responses as {data known, err, rdata} and their issue cycles
  logic [33:0] exp_q[$];
  int          stamp_q[$];

  logic [31:0] sh_ram [RAM_WORDS];
  logic [7:0]  sh_gpio_in, sh_gpio_out, sh_gpio_oe, sh_gpio_state, sh_gpio_en;
  logic [31:0] sh_tmr_cmp;
  logic        sh_tmr_en, sh_tmr_state;
  logic [1:0]  sh_intc_en;

  soc_top #(.RamDepth(RAM_WORDS), .GpioWidth(8)) soc_top_i (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .req_i     (req),
    .we_i      (we),
    .addr_i    (addr),
    .wdata_i   (wdata),
    .rvalid_o  (rvalid),
    .rdata_o   (rdata),
    .err_o     (err),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_en_o (gpio_en),
    .irq_o     (irq),
    .irq_id_o  (irq_id)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_eq(input logic [31:0] act, input logic [31:0] expected,
                          input string what);
    if (act !== expected) begin
      abort_run($sformatf("FAIL %0t ns: %s, got %0h, expected %0h",
                          $time, what, act, expected));
    end
  endtask

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      abort_run($sformatf("timeout: test did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  // address dependent fill pattern
  function automatic logic [31:0] fill_word(input logic [15:0] a);
    return {a, ~a} ^ 32'h6b2d_9e41;
  endfunction

  function automatic logic [1:0] pending_now();
    logic [1:0] p;
    p[IRQ_GPIO]  = |(sh_gpio_state & sh_gpio_en);
    p[IRQ_TIMER] = sh_tmr_state;
    return p;
  endfunction

  // lowest enabled pending source wins and ids start at 1
  function automatic logic [1:0] claim_id();
    logic [1:0] act;
    act = pending_now() & sh_intc_en;
    if (act[0]) begin
      return 2'd1;
    end else if (act[1]) begin
      return 2'd2;
    end
    return 2'd0;
  endfunction

  function automatic logic [33:0] expect_rsp(input logic is_wr, input logic [15:0] a);
    logic [31:0] val;
    logic        bad;
    logic        known;
    val   = '0;
    bad   = 1'b0;
    known = 1'b1;
    if (a < 16'h0400) begin
      val = sh_ram[a[9:2]];
    end else if (a[15:12] == GPIO_BASE[15:12]) begin
      case (a[11:0])
        GPIO_DATA_IN: begin
          val = {24'h0, sh_gpio_in};
          bad = is_wr;
        end
        GPIO_DATA_OUT:   val = {24'h0, sh_gpio_out};
        GPIO_OE:         val = {24'h0, sh_gpio_oe};
        GPIO_INTR_STATE: val = {24'h0, sh_gpio_state};
        GPIO_INTR_EN:    val = {24'h0, sh_gpio_en};
        default:         bad = 1'b1;
      endcase
    end else if (a[15:12] == TIMER_BASE[15:12]) begin
      case (a[11:0])
        // count runs freely so only its range is checked
        TMR_COUNT:      known = 1'b0;
        TMR_COMPARE:    val = sh_tmr_cmp;
        TMR_CTRL:       val = {31'h0, sh_tmr_en};
        TMR_INTR_STATE: val = {31'h0, sh_tmr_state};
        default:        bad = 1'b1;
      endcase
    end else if (a[15:12] == INTC_BASE[15:12]) begin
      case (a[11:0])
        INTC_PENDING: begin
          val = {30'h0, pending_now()};
          bad = is_wr;
        end
        INTC_ENABLE: val = {30'h0, sh_intc_en};
        INTC_CLAIM: begin
          val = {30'h0, claim_id()};
          bad = is_wr;
        end
        default: bad = 1'b1;
      endcase
    end else begin
      bad = 1'b1;
    end
    // writes and errors answer with zero data
    if (bad || is_wr) begin
      val   = '0;
      known = 1'b1;
    end
    return {known, bad, val};
  endfunction

  task automatic update_shadow(input logic [15:0] a, input logic [31:0] d);
    if (a < 16'h0400) begin
      sh_ram[a[9:2]] = d;
    end else if (a[15:12] == GPIO_BASE[15:12]) begin
      case (a[11:0])
        GPIO_DATA_OUT:   sh_gpio_out = d[7:0];
        GPIO_OE:         sh_gpio_oe = d[7:0];
        GPIO_INTR_STATE: sh_gpio_state = sh_gpio_state & ~d[7:0];
        GPIO_INTR_EN:    sh_gpio_en = d[7:0];
        default:         ;
      endcase
    end else if (a[15:12] == TIMER_BASE[15:12]) begin
      case (a[11:0])
        TMR_COMPARE: sh_tmr_cmp = d;
        TMR_CTRL:    sh_tmr_en = d[0];
        // a running timer past compare sets it again at once
        TMR_INTR_STATE: begin
          if (d[0] && !sh_tmr_en) begin
            sh_tmr_state = 1'b0;
          end
        end
        default: ;
      endcase
    end else if (a == (INTC_BASE + INTC_ENABLE)) begin
      sh_intc_en = d[1:0];
    end
  endtask

  task automatic bus_write(input logic [15:0] a, input logic [31:0] d);
    logic [33:0] rsp;
    @(negedge clk);
    rsp   = expect_rsp(1'b1, a);
    req   = 1'b1;
    we    = 1'b1;
    addr  = a;
    wdata = d;
    exp_q.push_back(rsp);
    stamp_q.push_back(cyc);
    if (!rsp[32]) begin
      update_shadow(a, d);
    end
  endtask

  task automatic bus_read(input logic [15:0] a);
    @(negedge clk);
    req   = 1'b1;
    we    = 1'b0;
    addr  = a;
    wdata = '0;
    exp_q.push_back(expect_rsp(1'b0, a));
    stamp_q.push_back(cyc);
  endtask

  task automatic bus_idle(input int n);
    repeat (n) begin
      @(negedge clk);
      req = 1'b0;
      we  = 1'b0;
    end
  endtask

  // wait until every outstanding response has been checked
  task automatic drain_rsp();
    bus_idle(1);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  task automatic set_gpio(input logic [7:0] val);
    @(negedge clk);
    req           = 1'b0;
    sh_gpio_state = sh_gpio_state | (val & ~sh_gpio_in);
    sh_gpio_in    = val;
    gpio_in       = val;
  endtask

  always @(negedge clk) begin : compare_rsp
    logic [33:0] expected;
    int          stamp;
    if (rst_n) begin
      if (rvalid) begin
        if (exp_q.size() == 0) begin
          abort_run("response on rvalid_o without an outstanding request");
        end
        expected = exp_q.pop_front();
        stamp    = stamp_q.pop_front();
        check_eq(cyc - stamp, 1, "response latency in cycles");
        check_eq(err, expected[32], $sformatf("err_o for request at cycle %0d", stamp));
        if (expected[33]) begin
          check_eq(rdata, expected[31:0], $sformatf("rdata_o for request at cycle %0d", stamp));
        end
        last_rdata = rdata;
      end else if (exp_q.size() != 0 && cyc - stamp_q[0] > 1) begin
        abort_run("no response on rvalid_o one cycle after a request");
      end
    end
  end

  initial begin : stimulus
    int          i;
    int          t_start;
    logic [7:0]  idx;
    logic [31:0] rnd;
    req     = 1'b0;
    we      = 1'b0;
    addr    = '0;
    wdata   = '0;
    gpio_in = '0;
    rst_n   = 1'b0;
    {sh_gpio_in, sh_gpio_out, sh_gpio_oe, sh_gpio_state, sh_gpio_en} = '0;
    {sh_tmr_cmp, sh_tmr_en, sh_tmr_state, sh_intc_en} = '0;
    err_addrs = '{16'h0400, 16'h0ffc, 16'h4000, 16'h8000, 16'hfffc,
                  16'h1014, 16'h1100, 16'h2010, 16'h300c};
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_eq(rvalid, 0, "rvalid_o after reset");
    check_eq(err, 0, "err_o after reset");
    check_eq(gpio_out, 0, "gpio_o after reset");
    check_eq(gpio_en, 0, "gpio_en_o after reset");
    check_eq(irq, 0, "irq_o after reset");
    check_eq(irq_id, 0, "irq_id_o after reset");

    // ram fill followed by random back-to-back traffic
    for (i = 0; i < RAM_WORDS; i++) begin
      bus_write({i[13:0], 2'b00}, fill_word({i[13:0], 2'b00}));
    end
    repeat (200) begin
      idx = $random(seed);
      rnd = $random(seed);
      if (rnd[0]) begin
        bus_write({6'h0, idx, 2'b00}, $random(seed));
      end else begin
        bus_read({6'h0, idx, 2'b00});
      end
      if (rnd[3:1] == 3'd0) begin
        bus_idle(1);
      end
    end
    bus_write(16'h03fc, 32'hcafe_f00d);
    bus_read(16'h03fc);
    drain_rsp();

    // holes, unknown offsets and read-only registers
    for (i = 0; i < 9; i++) begin
      bus_read(err_addrs[i]);
      bus_write(err_addrs[i], 32'hdead_beef);
    end
    bus_write(GPIO_BASE + GPIO_DATA_IN, 32'h0000_00ff);
    bus_write(INTC_BASE + INTC_PENDING, 32'h3);
    bus_write(INTC_BASE + INTC_CLAIM, 32'h3);
    bus_read(16'h0000);
    bus_read(16'h03fc);
    bus_read(GPIO_BASE + GPIO_DATA_OUT);
    bus_read(TIMER_BASE + TMR_COMPARE);
    bus_read(INTC_BASE + INTC_ENABLE);
    drain_rsp();

    // gpio outputs and synchronized inputs
    bus_write(GPIO_BASE + GPIO_DATA_OUT, 32'h0000_00a5);
    bus_write(GPIO_BASE + GPIO_OE, 32'h0000_000f);
    bus_read(GPIO_BASE + GPIO_DATA_OUT);
    bus_read(GPIO_BASE + GPIO_OE);
    drain_rsp();
    check_eq(gpio_out, 8'ha5, "gpio_o");
    check_eq(gpio_en, 8'h0f, "gpio_en_o");
    set_gpio(8'h3c);
    bus_idle(4);
    bus_read(GPIO_BASE + GPIO_DATA_IN);
    bus_read(GPIO_BASE + GPIO_INTR_STATE);
    drain_rsp();
    check_eq(irq, 0, "irq_o with gpio interrupts disabled");

    // gpio edge interrupt through the controller
    bus_write(INTC_BASE + INTC_ENABLE, 32'h1);
    bus_write(GPIO_BASE + GPIO_INTR_EN, 32'h0000_0004);
    bus_idle(3);
    check_eq(irq, 1, "irq_o from gpio edge");
    check_eq(irq_id, 1, "irq_id_o from gpio edge");
    bus_read(INTC_BASE + INTC_CLAIM);
    bus_read(INTC_BASE + INTC_PENDING);
    bus_write(GPIO_BASE + GPIO_INTR_STATE, 32'h0000_003c);
    bus_idle(3);
    check_eq(irq, 0, "irq_o after gpio clear");
    check_eq(irq_id, 0, "irq_id_o after gpio clear");
    bus_read(GPIO_BASE + GPIO_INTR_STATE);
    drain_rsp();

    // timer expiry with the gpio source idle
    bus_write(INTC_BASE + INTC_ENABLE, 32'h3);
    bus_write(TIMER_BASE + TMR_COMPARE, 32'd40);
    bus_write(TIMER_BASE + TMR_CTRL, 32'h1);
    t_start = cyc;
    bus_idle(1);
    while (!irq) begin
      @(negedge clk);
    end
    check_eq(cyc - t_start >= 40, 1, "timer irq not before compare is reached");
    sh_tmr_state = 1'b1;
    check_eq(irq_id, 2, "irq_id_o from timer");
    bus_read(TIMER_BASE + TMR_COUNT);
    drain_rsp();
    check_eq(last_rdata >= 32'd40, 1, "timer count at least compare");
    bus_read(TIMER_BASE + TMR_INTR_STATE);
    bus_read(INTC_BASE + INTC_PENDING);
    bus_read(INTC_BASE + INTC_CLAIM);

    // both sources active with the lowest index first
    bus_write(GPIO_BASE + GPIO_INTR_EN, 32'h0000_0084);
    set_gpio(8'hbc);
    bus_idle(4);
    check_eq(irq_id, 1, "irq_id_o with both sources");
    bus_read(INTC_BASE + INTC_CLAIM);
    bus_write(INTC_BASE + INTC_ENABLE, 32'h2);
    bus_idle(2);
    check_eq(irq_id, 2, "irq_id_o with gpio masked");
    bus_read(INTC_BASE + INTC_CLAIM);
    bus_write(TIMER_BASE + TMR_CTRL, 32'h0);
    bus_write(TIMER_BASE + TMR_INTR_STATE, 32'h1);
    bus_idle(3);
    check_eq(irq, 0, "irq_o after timer stop");
    check_eq(irq_id, 0, "irq_id_o after timer stop");
    bus_read(TIMER_BASE + TMR_INTR_STATE);
    bus_read(INTC_BASE + INTC_CLAIM);
    bus_read(INTC_BASE + INTC_PENDING);
    drain_rsp();

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
design/soc_pkg.sv
design/soc_bus_if.sv
design/bus_xbar.sv
design/sram_dev.sv
design/gpio_dev.sv
design/timer_dev.sv
design/intr_ctrl.sv
design/soc_top.sv
sim/tb_top.sv
